/* Makefile */
SIM  := obj_dir/Vtb_quad_bram_ctrl
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -j 0 -Mdir obj_dir \
		--top-module tb_quad_bram_ctrl -f files.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

/* bench/tb_quad_bram_ctrl.sv */
module tb_quad_bram_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    import cnn_quad_pkg::*;

    localparam int NUM_CE          = 8;
    localparam int SEQ_READ_LAT    = 3;
    localparam int PRIME_ROWS      = 4;
    // Six sequence reads per output pixel
    localparam int READS_PER_PIXEL = 6;
    localparam int FLUSH_CYCLES    = NUM_CE + SEQ_READ_LAT;
    localparam int ACCEPT_LIMIT    = 20;
    localparam int COMPLETE_LIMIT  = 5000;

    logic                  clk;
    logic                  rst;
    logic [DIM_W-1:0]      num_input_cols;
    logic [DIM_W-1:0]      num_input_rows;
    logic [DIM_W-1:0]      num_output_cols;
    logic [DIM_W-1:0]      num_output_rows;
    logic [PFB_CNT_W-1:0]  pfb_full_count;
    logic [SEQ_ADDR_W-1:0] seq_full_count;
    logic                  job_start;
    logic                  job_accept;
    logic                  job_fetch_request;
    logic                  job_fetch_ack;
    logic                  job_fetch_complete;
    logic                  job_complete;
    logic                  job_complete_ack;
    logic                  pipeline_flushed;
    logic                  last_kernel;
    logic                  pfb_rden;
    logic [DIM_W-1:0]      input_row;
    logic [DIM_W-1:0]      input_col;
    logic                  seq_rden;
    logic [SEQ_ADDR_W-1:0] seq_addr;
    logic [NUM_CE-1:0]     ce_execute;
    logic [NUM_CE-1:0]     next_kernel;
    job_state_t            state;

    int          errors = 0;
    int          timeouts = 0;
    logic        seen_start;
    logic [31:0] lfsr_state = 32'hc385;
    // Fetcher and flush model state
    logic        fetch_busy;
    int          fetch_wait;
    int          flush_wait;
    // Scoreboard trackers
    logic        job_open;
    int          rd_cnt;
    int          nk_cnt;
    // Buffer reads in the current job
    int          in_reads;

    quad_bram_ctrl #(
        .NUM_CE       (NUM_CE),
        .SEQ_READ_LAT (SEQ_READ_LAT),
        .PRIME_ROWS   (PRIME_ROWS)
    ) dut0 (
        .clk                (clk),
        .rst                (rst),
        .num_input_cols     (num_input_cols),
        .num_input_rows     (num_input_rows),
        .num_output_cols    (num_output_cols),
        .num_output_rows    (num_output_rows),
        .pfb_full_count     (pfb_full_count),
        .seq_full_count     (seq_full_count),
        .job_start          (job_start),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete       (job_complete),
        .job_complete_ack   (job_complete_ack),
        .pipeline_flushed   (pipeline_flushed),
        .last_kernel        (last_kernel),
        .pfb_rden           (pfb_rden),
        .input_row          (input_row),
        .input_col          (input_col),
        .seq_rden           (seq_rden),
        .seq_addr           (seq_addr),
        .ce_execute         (ce_execute),
        .next_kernel        (next_kernel),
        .state              (state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic flag_error(input string msg);
        errors++;
        $display("ERR %0t %s", $time, msg);
    endtask

    // Galois step with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // Fetcher and flush models
    ////////////////////////////////////////

    // Ack on request and complete after a random delay
    initial begin
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        fetch_busy         = 1'b0;
        fetch_wait         = 0;
        forever begin
            @(posedge clk);
            #1;
            job_fetch_ack      = 1'b0;
            job_fetch_complete = 1'b0;
            if (rst) begin
                fetch_busy = 1'b0;
            end else if (fetch_busy) begin
                if (fetch_wait == 0) begin
                    job_fetch_complete = 1'b1;
                    fetch_busy         = 1'b0;
                end else begin
                    fetch_wait--;
                end
            end else if (job_fetch_request) begin
                job_fetch_ack = 1'b1;
                fetch_busy    = 1'b1;
                fetch_wait    = 1 + rand_bits(3);
            end
        end
    end

    // Flush reported once the compute chain could have drained
    initial begin
        pipeline_flushed = 1'b0;
        flush_wait       = 0;
        forever begin
            @(posedge clk);
            #1;
            if (state == ST_WAIT_FLUSH) begin
                if (flush_wait == FLUSH_CYCLES) begin
                    pipeline_flushed = 1'b1;
                end else begin
                    flush_wait++;
                end
            end else begin
                pipeline_flushed = 1'b0;
                flush_wait       = 0;
            end
        end
    end

    ////////////////////////////////////////
    // Trackers
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            job_open <= 1'b0;
            rd_cnt   <= 0;
            nk_cnt   <= 0;
            in_reads <= 0;
        end else begin
            if (job_accept) begin
                job_open <= 1'b1;
            end else if (job_complete_ack) begin
                job_open <= 1'b0;
            end
            // Reads since the last buffer fill
            if (job_fetch_complete || job_complete_ack) begin
                rd_cnt <= 0;
            end else if (pfb_rden) begin
                rd_cnt <= rd_cnt + 1;
            end
            // Kernel strobes in the current job
            if (job_accept) begin
                nk_cnt <= 0;
            end else if (next_kernel[0]) begin
                nk_cnt <= nk_cnt + 1;
            end
            // Position counters clear on the completion ack
            if (job_complete_ack) begin
                in_reads <= 0;
            end else if (pfb_rden) begin
                in_reads <= in_reads + 1;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !seen_start |-> (state == ST_IDLE && !job_accept && !job_fetch_request
                         && !job_complete && !pfb_rden && !seq_rden
                         && ce_execute == '0 && next_kernel == '0))
        else flag_error("outputs active before first job_start");

    a_accept: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE && job_start) |=> job_accept)
        else flag_error("job_accept missing after job_start in idle");

    a_accept_once: assert property (@(posedge clk) disable iff (rst)
        job_accept |-> !job_open)
        else flag_error("second job_accept before completion ack");

    a_accept_pulse: assert property (@(posedge clk) disable iff (rst)
        job_accept |=> !job_accept)
        else flag_error("job_accept longer than one cycle");

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (job_fetch_request && !job_fetch_ack) |=> job_fetch_request)
        else flag_error("job_fetch_request dropped without ack");

    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        (job_fetch_request && job_fetch_ack) |=> !job_fetch_request)
        else flag_error("job_fetch_request still high after ack");

    a_rd_limit: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> (rd_cnt < int'(pfb_full_count)))
        else flag_error("more pfb_rden pulses than pfb_full_count");

    // Input position from the running read count of the job
    a_in_pos: assert property (@(posedge clk) disable iff (rst)
        (int'(input_col) == in_reads % (int'(num_input_cols) + 1))
        && (int'(input_row) == in_reads / (int'(num_input_cols) + 1)))
        else flag_error("input_row or input_col does not match buffer reads");

    a_exec_lat: assert property (@(posedge clk) disable iff (rst)
        ce_execute[0] == $past(seq_rden, SEQ_READ_LAT))
        else flag_error("ce_execute[0] does not follow seq_rden latency");

    for (genvar i = 1; i < NUM_CE; i++) begin : g_chain
        a_exec_shift: assert property (@(posedge clk) disable iff (rst)
            ce_execute[i] == $past(ce_execute[i-1]))
            else flag_error($sformatf("ce_execute[%0d] shift mismatch", i));

        a_kernel_shift: assert property (@(posedge clk) disable iff (rst)
            next_kernel[i] == $past(next_kernel[i-1]))
            else flag_error($sformatf("next_kernel[%0d] shift mismatch", i));
    end

    a_addr_step: assert property (@(posedge clk) disable iff (rst)
        seq_rden |=> (seq_addr == $past(seq_addr) + 12'd1))
        else flag_error("seq_addr did not advance by one on read");

    // Address only holds or restarts at zero without a read
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        !seq_rden |=> (seq_addr == $past(seq_addr) || seq_addr == '0))
        else flag_error("seq_addr moved without a read");

    a_kernel_count: assert property (@(posedge clk) disable iff (rst)
        $rose(job_complete) |-> (nk_cnt == int'(num_output_rows) + 1))
        else flag_error("next_kernel[0] pulse count wrong at completion");

    a_cpl_hold: assert property (@(posedge clk) disable iff (rst)
        (job_complete && !job_complete_ack) |=> job_complete)
        else flag_error("job_complete dropped without ack");

    a_cpl_idle: assert property (@(posedge clk) disable iff (rst)
        (job_complete && job_complete_ack) |=> (state == ST_IDLE && !job_complete))
        else flag_error("not idle one cycle after completion ack");

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic run_job(input int in_cols, input int in_rows, input int out_cols,
                           input int out_rows, input int pfb_cnt);
        int n;
        num_input_cols  = DIM_W'(in_cols);
        num_input_rows  = DIM_W'(in_rows);
        num_output_cols = DIM_W'(out_cols);
        num_output_rows = DIM_W'(out_rows);
        pfb_full_count  = PFB_CNT_W'(pfb_cnt);
        // One full row of pixels per sequence pass
        seq_full_count  = SEQ_ADDR_W'((out_cols + 1) * READS_PER_PIXEL);
        repeat (3) @(posedge clk);
        #1;
        job_start  = 1'b1;
        seen_start = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!job_accept && n < ACCEPT_LIMIT);
        job_start = 1'b0;
        if (!job_accept) begin
            timeouts++;
            $display("Timeout: job_accept not seen within %0d cycles", ACCEPT_LIMIT);
        end else begin
            n = 0;
            while (!job_complete && n < COMPLETE_LIMIT) begin
                @(posedge clk);
                #1;
                n++;
            end
            if (!job_complete) begin
                timeouts++;
                $display("Timeout: job_complete not seen within %0d cycles",
                         COMPLETE_LIMIT);
            end else begin
                // Hold complete a little before acknowledging
                repeat (2) @(posedge clk);
                #1;
                job_complete_ack = 1'b1;
                @(posedge clk);
                #1;
                job_complete_ack = 1'b0;
            end
        end
    endtask

    initial begin
        rst              = 1'b1;
        seen_start       = 1'b0;
        job_start        = 1'b0;
        job_complete_ack = 1'b0;
        last_kernel      = 1'b1;
        num_input_cols   = '0;
        num_input_rows   = '0;
        num_output_cols  = '0;
        num_output_rows  = '0;
        pfb_full_count   = '0;
        seq_full_count   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // Quiet idle stretch before the first job
        repeat (5) @(posedge clk);
        #1;
        run_job(3, 5, 1, 2, 6);
        if (timeouts == 0) begin
            run_job(2, 4, 0, 1, 9);
        end
        if (timeouts == 0) begin
            run_job(4, 6, 2, 3, 5);
        end
        repeat (20) @(posedge clk);
        #1;
        $display("Closing counts: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/cnn_quad_pkg.sv
rtl/job_ctrl.sv
rtl/pfb_feed.sv
rtl/seq_reader.sv
rtl/ce_dispatch.sv
rtl/quad_bram_ctrl.sv
bench/tb_quad_bram_ctrl.sv

/* rtl/ce_dispatch.sv */
module ce_dispatch #(
    parameter int NUM_CE       = 8,
    parameter int SEQ_READ_LAT = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              seq_rden,
    input  logic              kernel_end,
    output logic [NUM_CE-1:0] ce_execute,
    output logic [NUM_CE-1:0] next_kernel
);

    // Read strobe one cycle short of the BRAM latency
    logic                    exec_in;
    // Per element {execute, next kernel}
    logic [NUM_CE-1:0][1:0]  stage;

    generate
        if (SEQ_READ_LAT > 1) begin : g_lat
            logic [SEQ_READ_LAT-2:0] rden_dly;

            always_ff @(posedge clk) begin
                if (rst) begin
                    rden_dly <= '0;
                end else begin
                    rden_dly[0] <= seq_rden;
                    for (int i = 1; i < SEQ_READ_LAT - 1; i++) begin
                        rden_dly[i] <= rden_dly[i-1];
                    end
                end
            end

            assign exec_in = rden_dly[SEQ_READ_LAT-2];
        end else begin : g_no_lat
            // Single-cycle BRAM, first stage is the whole delay
            assign exec_in = seq_rden;
        end
    endgenerate

    // Both strobes ripple one element per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else begin
            stage[0] <= {exec_in, kernel_end};
            for (int i = 1; i < NUM_CE; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CE; i++) begin
            ce_execute[i]  = stage[i][1];
            next_kernel[i] = stage[i][0];
        end
    end

endmodule

/* rtl/cnn_quad_pkg.sv */
package cnn_quad_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Row and column counts, sized for a 1024-deep BRAM
    localparam int DIM_W      = 10;
    // Prefetch-buffer entry count
    localparam int PFB_CNT_W  = 10;
    // Sequence BRAM address and data count
    localparam int SEQ_ADDR_W = 12;
    // Per-pixel cycle counter
    localparam int CYC_W      = 3;

    // Last cycle-counter value, six reads per output pixel
    localparam logic [CYC_W-1:0] CYCLE_COUNT = 3'd5;

    ////////////////////////////////////////
    // Job FSM states
    ////////////////////////////////////////

    // One-hot
    typedef enum logic [5:0] {
        ST_IDLE          = 6'b000001,
        ST_PRIME         = 6'b000010,
        ST_WAIT_FETCH    = 6'b000100,
        ST_ACTIVE        = 6'b001000,
        ST_WAIT_FLUSH    = 6'b010000,
        ST_SEND_COMPLETE = 6'b100000
    } job_state_t;

endpackage

/* rtl/job_ctrl.sv */
module job_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           job_start,
    input  logic                           job_fetch_ack,
    input  logic                           job_fetch_complete,
    input  logic                           job_complete_ack,
    input  logic                           pipeline_flushed,
    input  logic                           pfb_empty,
    input  logic                           primed,
    input  logic [cnn_quad_pkg::DIM_W-1:0] input_row,
    input  logic [cnn_quad_pkg::DIM_W-1:0] num_input_rows,
    input  logic                           row_done,
    input  logic                           last_row,
    output logic                           job_accept,
    output logic                           job_fetch_request,
    output logic                           job_complete,
    output logic                           prime_en,
    output logic                           run,
    output logic                           row_restart,
    output cnn_quad_pkg::job_state_t       state
);
    import cnn_quad_pkg::*;

    // State to resume once a fetch completes
    job_state_t return_state;
    // More input rows still to come from the fetcher
    logic       need_fetch;

    // One extra bit so num_input_rows + 1 cannot wrap
    assign need_fetch = ({1'b0, input_row} < ({1'b0, num_input_rows} + 1'b1));

    // Buffer reads run while priming and while executing
    assign prime_en = (state == ST_PRIME) || (state == ST_ACTIVE);
    // Sequence reads only while executing
    assign run      = (state == ST_ACTIVE);

    ////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            return_state      <= ST_PRIME;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            row_restart       <= 1'b0;
        end else begin
            // Pulses default low
            job_accept  <= 1'b0;
            row_restart <= 1'b0;
            unique case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    // Enough rows loaded, start the first output row
                    if (primed) begin
                        row_restart <= 1'b1;
                        state       <= ST_ACTIVE;
                    end else if (pfb_empty) begin
                        // Buffer drained before priming done
                        return_state      <= ST_PRIME;
                        job_fetch_request <= 1'b1;
                        state             <= ST_WAIT_FETCH;
                    end
                end
                ST_WAIT_FETCH: begin
                    // Request held until the fetcher takes it
                    if (job_fetch_ack || job_fetch_complete) begin
                        job_fetch_request <= 1'b0;
                    end
                    if (job_fetch_complete) begin
                        state <= return_state;
                    end
                end
                ST_ACTIVE: begin
                    if (row_done) begin
                        if (last_row) begin
                            state <= ST_WAIT_FLUSH;
                        end else begin
                            // Rearm sequence reads for the next row
                            row_restart <= 1'b1;
                            if (need_fetch) begin
                                return_state      <= ST_ACTIVE;
                                job_fetch_request <= 1'b1;
                                state             <= ST_WAIT_FETCH;
                            end
                        end
                    end
                end
                ST_WAIT_FLUSH: begin
                    // Compute chain drains before completion
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= ST_SEND_COMPLETE;
                    end
                end
                ST_SEND_COMPLETE: begin
                    // Complete held until acknowledged
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/pfb_feed.sv */
module pfb_feed #(
    parameter int PRIME_ROWS = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               prime_en,
    input  logic                               job_fetch_ack,
    input  logic                               job_fetch_complete,
    input  logic                               job_complete_ack,
    input  logic [cnn_quad_pkg::PFB_CNT_W-1:0] pfb_full_count,
    input  logic [cnn_quad_pkg::DIM_W-1:0]     num_input_cols,
    output logic                               pfb_rden,
    output logic                               pfb_empty,
    output logic                               primed,
    output logic [cnn_quad_pkg::DIM_W-1:0]     input_row,
    output logic [cnn_quad_pkg::DIM_W-1:0]     input_col
);
    import cnn_quad_pkg::*;

    // Entries left in the prefetch buffer
    logic [PFB_CNT_W-1:0] pfb_count;
    // Between fetch ack and fetch complete
    logic                 fetch_in_progress;

    assign pfb_empty = (pfb_count == '0);
    // One read per entry while enabled
    assign pfb_rden  = prime_en && !pfb_empty;
    assign primed    = (input_row >= DIM_W'(PRIME_ROWS));

    ////////////////////////////////////////
    // Fetch tracking and entry count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_complete_ack) begin
            fetch_in_progress <= 1'b0;
            pfb_count         <= '0;
        end else begin
            if (job_fetch_complete) begin
                fetch_in_progress <= 1'b0;
            end else if (job_fetch_ack) begin
                fetch_in_progress <= 1'b1;
            end
            // Buffer is full once the fetcher reports completion
            if (job_fetch_complete && fetch_in_progress) begin
                pfb_count <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Input row and column position
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_complete_ack) begin
            input_row <= '0;
            input_col <= '0;
        end else if (pfb_rden) begin
            // Last column wraps into the next row
            if (input_col == num_input_cols) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

endmodule

/* rtl/quad_bram_ctrl.sv */
module quad_bram_ctrl #(
    parameter int NUM_CE       = 8,
    parameter int SEQ_READ_LAT = 3,
    parameter int PRIME_ROWS   = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    // Job dimensions, last index of each
    input  logic [cnn_quad_pkg::DIM_W-1:0]      num_input_cols,
    input  logic [cnn_quad_pkg::DIM_W-1:0]      num_input_rows,
    input  logic [cnn_quad_pkg::DIM_W-1:0]      num_output_cols,
    input  logic [cnn_quad_pkg::DIM_W-1:0]      num_output_rows,
    input  logic [cnn_quad_pkg::PFB_CNT_W-1:0]  pfb_full_count,
    input  logic [cnn_quad_pkg::SEQ_ADDR_W-1:0] seq_full_count,
    // Job handshakes
    input  logic                                job_start,
    output logic                                job_accept,
    output logic                                job_fetch_request,
    input  logic                                job_fetch_ack,
    input  logic                                job_fetch_complete,
    output logic                                job_complete,
    input  logic                                job_complete_ack,
    input  logic                                pipeline_flushed,
    input  logic                                last_kernel,
    // Buffer and BRAM reads
    output logic                                pfb_rden,
    output logic [cnn_quad_pkg::DIM_W-1:0]      input_row,
    output logic [cnn_quad_pkg::DIM_W-1:0]      input_col,
    output logic                                seq_rden,
    output logic [cnn_quad_pkg::SEQ_ADDR_W-1:0] seq_addr,
    // Compute element strobes
    output logic [NUM_CE-1:0]                   ce_execute,
    output logic [NUM_CE-1:0]                   next_kernel,
    output cnn_quad_pkg::job_state_t            state
);

    // FSM to buffer feed
    logic prime_en;
    logic pfb_empty;
    logic primed;
    // FSM to sequence reader
    logic run;
    logic row_restart;
    logic row_done;
    logic last_row;
    // Sequence reader to dispatch
    logic kernel_end;

    job_ctrl u_job_ctrl (
        .clk                (clk),
        .rst                (rst),
        .job_start          (job_start),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .pipeline_flushed   (pipeline_flushed),
        .pfb_empty          (pfb_empty),
        .primed             (primed),
        .input_row          (input_row),
        .num_input_rows     (num_input_rows),
        .row_done           (row_done),
        .last_row           (last_row),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_complete       (job_complete),
        .prime_en           (prime_en),
        .run                (run),
        .row_restart        (row_restart),
        .state              (state)
    );

    pfb_feed #(
        .PRIME_ROWS (PRIME_ROWS)
    ) u_pfb_feed (
        .clk                (clk),
        .rst                (rst),
        .prime_en           (prime_en),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .pfb_full_count     (pfb_full_count),
        .num_input_cols     (num_input_cols),
        .pfb_rden           (pfb_rden),
        .pfb_empty          (pfb_empty),
        .primed             (primed),
        .input_row          (input_row),
        .input_col          (input_col)
    );

    seq_reader u_seq_reader (
        .clk              (clk),
        .rst              (rst),
        .run              (run),
        .row_restart      (row_restart),
        .job_complete_ack (job_complete_ack),
        .seq_full_count   (seq_full_count),
        .num_output_cols  (num_output_cols),
        .num_output_rows  (num_output_rows),
        .last_kernel      (last_kernel),
        .seq_rden         (seq_rden),
        .seq_addr         (seq_addr),
        .kernel_end       (kernel_end),
        .row_done         (row_done),
        .last_row         (last_row)
    );

    ce_dispatch #(
        .NUM_CE       (NUM_CE),
        .SEQ_READ_LAT (SEQ_READ_LAT)
    ) u_ce_dispatch (
        .clk         (clk),
        .rst         (rst),
        .seq_rden    (seq_rden),
        .kernel_end  (kernel_end),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel)
    );

endmodule

/* rtl/seq_reader.sv */
module seq_reader (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                run,
    input  logic                                row_restart,
    input  logic                                job_complete_ack,
    input  logic [cnn_quad_pkg::SEQ_ADDR_W-1:0] seq_full_count,
    input  logic [cnn_quad_pkg::DIM_W-1:0]      num_output_cols,
    input  logic [cnn_quad_pkg::DIM_W-1:0]      num_output_rows,
    input  logic                                last_kernel,
    output logic                                seq_rden,
    output logic [cnn_quad_pkg::SEQ_ADDR_W-1:0] seq_addr,
    output logic                                kernel_end,
    output logic                                row_done,
    output logic                                last_row
);
    import cnn_quad_pkg::*;

    // Sequence words still to read in this row
    logic [SEQ_ADDR_W-1:0] data_count;
    // Read cycle within the current output pixel
    logic [CYC_W-1:0]      cycle_counter;
    logic [DIM_W-1:0]      output_row;
    logic [DIM_W-1:0]      output_col;
    // Last read of a pixel
    logic                  pix_wrap;
    logic                  col_last;

    // No read during the reload cycle
    assign seq_rden = run && !row_restart && (data_count != '0);

    assign pix_wrap   = seq_rden && (cycle_counter == CYCLE_COUNT);
    assign col_last   = (output_col == num_output_cols);
    assign kernel_end = pix_wrap && col_last;
    assign row_done   = kernel_end && last_kernel;
    assign last_row   = (output_row == num_output_rows);

    ////////////////////////////////////////
    // Address and data count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_complete_ack) begin
            seq_addr   <= '0;
            data_count <= '0;
        end else if (row_restart) begin
            // Each output row replays the sequence from word 0
            seq_addr   <= '0;
            data_count <= seq_full_count;
        end else if (seq_rden) begin
            seq_addr   <= seq_addr + 1'b1;
            data_count <= data_count - 1'b1;
        end
    end

    // Steps once per read and wraps after CYCLE_COUNT
    always_ff @(posedge clk) begin
        if (rst || job_complete_ack) begin
            cycle_counter <= '0;
        end else if (pix_wrap) begin
            cycle_counter <= '0;
        end else if (seq_rden) begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Output position
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || job_complete_ack) begin
            output_row <= '0;
            output_col <= '0;
        end else if (pix_wrap) begin
            if (col_last) begin
                output_col <= '0;
                // Row advances only after the final kernel pass
                if (last_kernel) begin
                    output_row <= output_row + 1'b1;
                end
            end else begin
                output_col <= output_col + 1'b1;
            end
        end
    end

endmodule
